/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_dmm_top
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
rtl/dmm_pkg.sv
rtl/clk_timer.sv
rtl/spi_reg_bank.sv
rtl/seq_acq_fsm.sv
rtl/output_mode_mux.sv
rtl/dmm_top.sv
sim/tb_dmm_top.sv

/* rtl/clk_timer.sv */
/*
  one-shot down-counter, load N gives done N+1 clk later.
  reload is allowed only when idle or in the done cycle.
*/

`timescale 1ns/100ps
`default_nettype none

module clk_timer #(
  parameter int TIMER_W = 24
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               load_i,
  input  logic [TIMER_W-1:0] count_i,
  output logic               done_o
);

  logic [TIMER_W-1:0] cnt;
  logic               busy;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (load_i) begin
      busy <= 1'b1;
      cnt  <= count_i;
    end else if (busy) begin
      if (cnt == '0)
        busy <= 1'b0;                // expired, wait for next load
      else
        cnt <= cnt - 1'b1;
    end
  end

  assign done_o = busy && (cnt == '0);    // high in the zero cycle

  // a load mid-count would silently shorten an interval
  a_no_reload: assert property (@(posedge clk) disable iff (reset_i)
    load_i |-> !busy || done_o);

endmodule

`default_nettype wire

/* rtl/dmm_pkg.sv */
/*
  register map, mode codes and the bundle types of the acquisition core.
  count fields travel at register width. consumers use only the low TIMER_W bits.
*/

`default_nettype none

package dmm_pkg;

  localparam int REG_W   = 32;      // spi register width
  localparam int ADDR_W  = 7;       // address bits after the write flag
  localparam int SEQ_MAX = 4;       // sequence entries held

  //////////////////////////////////////////////////////////////////////
  // register map

  localparam logic [ADDR_W-1:0] REG_STATUS    = 7'd0;   // read only
  localparam logic [ADDR_W-1:0] REG_MODE      = 7'd1;
  localparam logic [ADDR_W-1:0] REG_DIRECT    = 7'd2;
  localparam logic [ADDR_W-1:0] REG_PRECHARGE = 7'd3;
  localparam logic [ADDR_W-1:0] REG_SEQ_N     = 7'd4;
  localparam logic [ADDR_W-1:0] REG_SEQ0      = 7'd5;   // seq1..3 follow
  localparam logic [ADDR_W-1:0] REG_SEQ1      = 7'd6;
  localparam logic [ADDR_W-1:0] REG_SEQ2      = 7'd7;
  localparam logic [ADDR_W-1:0] REG_SEQ3      = 7'd8;
  localparam logic [ADDR_W-1:0] REG_TRIG      = 7'd9;
  localparam logic [ADDR_W-1:0] REG_APERTURE  = 7'd10;  // last writable

  localparam logic [2:0] MODE_DIRECT   = 3'd0;
  localparam logic [2:0] MODE_SEQ_MOCK = 3'd6;   // sequencer + timer adc

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

  //////////////////////////////////////////////////////////////////////
  // types

  // one sample's switch setting, low bits of a seq register
  typedef struct packed {
    logic [1:0] pc_sw;    // 5:4
    logic [3:0] azmux;    // 3:0
  } seq_entry_t;

  // physical outputs, msb first here, lsb is leds
  typedef struct packed {
    logic       adc_reset_n;      // 25
    logic       meas_complete;    // 24
    logic       spi_interrupt;    // 23
    logic       adc_cmpr_latch;   // 22
    logic [3:0] adc_refmux;       // 21:18
    logic [3:0] azmux;            // 17:14
    logic [1:0] pc_sw;            // 13:12
    logic [7:0] monitor;          // 11:4
    logic [3:0] leds;             // 3:0
  } out_bundle_t;

  typedef struct packed {
    logic                          trig;
    logic [2:0]                    seq_n;
    seq_entry_t [SEQ_MAX-1:0]      seq;
    logic [REG_W-1:0]              precharge;   // clk counts
    logic [REG_W-1:0]              aperture;
  } seq_cfg_t;

endpackage

`default_nettype wire

/* rtl/dmm_top.sv */
/*
  acquisition control core with a timer in place of the adc.
  spi sck is sampled in clk, so its half period must be >= 4 clk.
*/

`timescale 1ns/100ps
`default_nettype none

module dmm_top #(
  parameter int TIMER_W = 24        // precharge / aperture counter width
) (
  input  logic       clk,
  input  logic       reset_i,

  // spi from mcu
  input  logic       spi_sck_i,
  input  logic       spi_sdi_i,
  input  logic       spi_cs_n_i,
  output logic       spi_sdo_o,

  input  logic [3:0] hw_flags_i,

  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_ctl_o,
  output logic       spi_interrupt_ctl_o,
  output logic       meas_complete_o
);

  logic [2:0]           mode;
  logic [2:0]           sample_idx_last;
  dmm_pkg::seq_cfg_t    seq_cfg;
  dmm_pkg::out_bundle_t direct_bundle;
  dmm_pkg::out_bundle_t seq_bundle;
  dmm_pkg::out_bundle_t out_bundle;     // registered, goes to pins

  spi_reg_bank #(
    .TIMER_W (TIMER_W)
  ) reg_bank (
    .clk               (clk),
    .reset_i           (reset_i),
    .sck_i             (spi_sck_i),
    .sdi_i             (spi_sdi_i),
    .cs_n_i            (spi_cs_n_i),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .sdo_o             (spi_sdo_o),
    .mode_o            (mode),
    .direct_o          (direct_bundle),
    .cfg_o             (seq_cfg)
  );

  seq_acq_fsm #(
    .TIMER_W (TIMER_W)
  ) seq_acq (
    .clk               (clk),
    .reset_i           (reset_i),
    .cfg_i             (seq_cfg),
    .bundle_o          (seq_bundle),
    .sample_idx_last_o (sample_idx_last)
  );

  output_mode_mux mode_mux (
    .clk      (clk),
    .reset_i  (reset_i),
    .mode_i   (mode),
    .direct_i (direct_bundle),
    .seq_i    (seq_bundle),
    .out_o    (out_bundle)
  );

  //////////////////////////////////////////////////////////////////////
  // pins, adc_reset_n has no pin on this board

  assign leds_o               = out_bundle.leds;
  assign monitor_o            = out_bundle.monitor;
  assign pc_sw_o              = out_bundle.pc_sw;
  assign azmux_o              = out_bundle.azmux;
  assign adc_refmux_o         = out_bundle.adc_refmux;
  assign adc_cmpr_latch_ctl_o = out_bundle.adc_cmpr_latch;
  assign spi_interrupt_ctl_o  = out_bundle.spi_interrupt;
  assign meas_complete_o      = out_bundle.meas_complete;

endmodule

`default_nettype wire

/* rtl/output_mode_mux.sv */
/*
  registered output source select one clk behind the source.
  modes other than direct and sequencer drive all zero.
*/

`timescale 1ns/100ps
`default_nettype none

module output_mode_mux (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic [2:0]             mode_i,
  input  dmm_pkg::out_bundle_t   direct_i,
  input  dmm_pkg::out_bundle_t   seq_i,
  output dmm_pkg::out_bundle_t   out_o
);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_o <= '0;                           // everything off
    end else begin
      case (mode_i)
        dmm_pkg::MODE_DIRECT:   out_o <= direct_i;   // bench / bring-up
        dmm_pkg::MODE_SEQ_MOCK: out_o <= seq_i;
        default:                out_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/seq_acq_fsm.sv */
/*
  free-running sample sequencer, held idle while trig is low.
  seq_n is taken at trigger, 0 runs one entry and values above 4 run four.
*/

`timescale 1ns/100ps
`default_nettype none

module seq_acq_fsm #(
  parameter int TIMER_W = 24
) (
  input  logic                   clk,
  input  logic                   reset_i,
  input  dmm_pkg::seq_cfg_t      cfg_i,
  output dmm_pkg::out_bundle_t   bundle_o,
  output logic [2:0]             sample_idx_last_o
);

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    PRECHARGE = 2'd1,
    APERTURE  = 2'd2,
    COMPLETE  = 2'd3
  } state_t;

  state_t              state;
  logic [2:0]          idx;          // current sample
  logic [2:0]          idx_nxt;
  logic [2:0]          n_eff;
  logic [2:0]          n_q;          // length in use
  dmm_pkg::seq_entry_t entry_q;      // switch setting for this sample
  logic                run_rst;
  logic                tmr_load;
  logic                tmr_done;
  logic [TIMER_W-1:0]  tmr_count;

  assign run_rst = reset_i | ~cfg_i.trig;   // trig low parks everything

  always_comb begin
    if (cfg_i.seq_n == 3'd0)
      n_eff = 3'd1;
    else if (cfg_i.seq_n > 3'(dmm_pkg::SEQ_MAX))
      n_eff = 3'(dmm_pkg::SEQ_MAX);             // only four entries exist
    else
      n_eff = cfg_i.seq_n;
  end

  assign idx_nxt = (idx + 3'd1 >= n_q) ? 3'd0 : idx + 3'd1;

  //////////////////////////////////////////////////////////////////////
  // timer, one for both intervals

  assign tmr_load = cfg_i.trig && (state == IDLE || state == COMPLETE
                    || (state == PRECHARGE && tmr_done));

  // precharge next unless leaving precharge
  assign tmr_count = (state == PRECHARGE) ? cfg_i.aperture[TIMER_W-1:0]
                                          : cfg_i.precharge[TIMER_W-1:0];

  clk_timer #(
    .TIMER_W (TIMER_W)
  ) timer (
    .clk     (clk),
    .reset_i (run_rst),
    .load_i  (tmr_load),
    .count_i (tmr_count),
    .done_o  (tmr_done)
  );

  //////////////////////////////////////////////////////////////////////
  // state

  always_ff @(posedge clk) begin
    if (run_rst) begin
      state <= IDLE;
      idx   <= 3'd0;
      n_q   <= 3'd1;
    end else begin
      case (state)
        IDLE: begin
          state <= PRECHARGE;                // trig seen
          n_q   <= n_eff;
        end
        PRECHARGE: if (tmr_done) state <= APERTURE;
        APERTURE:  if (tmr_done) state <= COMPLETE;
        COMPLETE: begin
          state <= PRECHARGE;                // next sample, no gap
          idx   <= idx_nxt;
        end
      endcase
    end
  end

  // entry latched on the way into precharge
  always_ff @(posedge clk) begin
    if (state == IDLE)
      entry_q <= cfg_i.seq[idx[1:0]];
    else if (state == COMPLETE)
      entry_q <= cfg_i.seq[idx_nxt[1:0]];
  end

  // survives trig clear, read back via status
  always_ff @(posedge clk) begin
    if (reset_i)
      sample_idx_last_o <= 3'd0;
    else if (state == COMPLETE)
      sample_idx_last_o <= idx;
  end

  //////////////////////////////////////////////////////////////////////
  // outputs

  always_comb begin
    bundle_o         = '0;
    bundle_o.monitor = {3'b0, idx, state};   // scope friendly
    if (state != IDLE) begin
      bundle_o.leds  = 4'b0001 << idx[1:0];  // one-hot index
      bundle_o.pc_sw = entry_q.pc_sw;
      bundle_o.azmux = entry_q.azmux;
    end
    bundle_o.adc_reset_n   = (state == APERTURE);  // mock adc integrating
    bundle_o.meas_complete = (state == COMPLETE);
    bundle_o.spi_interrupt = (state == COMPLETE);  // tells the mcu
  end

  a_idx_range: assert property (@(posedge clk) disable iff (run_rst)
    idx < n_q);

endmodule

`default_nettype wire

/* rtl/spi_reg_bank.sv */
/*
  spi mode 0 slave, sck is oversampled so half periods need >= 4 clk.
  frame is 8 bit cmd (write flag + addr) then 32 data bits, msb first.
  writes commit on cs release, only for exactly 40 bits.
*/

`timescale 1ns/100ps
`default_nettype none

module spi_reg_bank #(
  parameter int TIMER_W = 24
) (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   sck_i,
  input  logic                   sdi_i,
  input  logic                   cs_n_i,
  input  logic [3:0]             hw_flags_i,
  input  logic [2:0]             sample_idx_last_i,
  output logic                   sdo_o,
  output logic [2:0]             mode_o,
  output dmm_pkg::out_bundle_t   direct_o,
  output dmm_pkg::seq_cfg_t      cfg_o
);

  localparam int FRAME_BITS = 8 + dmm_pkg::REG_W;   // cmd byte + data

  logic [2:0] sck_q;      // 2 sync stages + edge history
  logic [1:0] sdi_q;
  logic [2:0] cs_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_rise;
  logic       cs_act;
  logic       sdi_s;

  logic [5:0]                    bit_cnt;
  logic                          overrun;    // more than a frame of clocks
  logic [FRAME_BITS-1:0]         rx_sr;
  logic [dmm_pkg::REG_W-1:0]     tx_sr;
  logic [dmm_pkg::ADDR_W-1:0]    rd_addr;
  logic [dmm_pkg::ADDR_W-1:0]    wr_addr;
  logic                          wr_en;
  logic [dmm_pkg::REG_W-1:0]     status;

  logic [dmm_pkg::REG_W-1:0] regs [dmm_pkg::REG_MODE:dmm_pkg::REG_APERTURE];

  function automatic logic is_rw(input logic [dmm_pkg::ADDR_W-1:0] a);
    return (a >= dmm_pkg::REG_MODE) && (a <= dmm_pkg::REG_APERTURE);
  endfunction

  function automatic logic [dmm_pkg::REG_W-1:0] read_word(
    input logic [dmm_pkg::ADDR_W-1:0] a
  );
    logic [dmm_pkg::REG_W-1:0] w;
    w = '0;                                  // unknown addr reads 0
    if (a == dmm_pkg::REG_STATUS)
      w = status;
    else if (is_rw(a))
      w = regs[a];
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // pin sampling

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sck_q <= '0;
      sdi_q <= '0;
      cs_q  <= '1;                           // deselected
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      sdi_q <= {sdi_q[0], sdi_i};
      cs_q  <= {cs_q[1:0], cs_n_i};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_act   = ~cs_q[1];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_rise  = cs_q[1] & ~cs_q[2];
  assign sdi_s    = sdi_q[1];                // aligned with sck_q[1]

  //////////////////////////////////////////////////////////////////////
  // frame

  always_ff @(posedge clk) begin
    if (reset_i) begin
      bit_cnt <= '0;
      overrun <= 1'b0;
    end else if (cs_fall) begin
      bit_cnt <= '0;
      overrun <= 1'b0;
    end else if (cs_act && sck_rise) begin
      if (bit_cnt == FRAME_BITS)
        overrun <= 1'b1;                     // extra clocks kill the write
      else
        bit_cnt <= bit_cnt + 6'd1;
    end
  end

  // shift data, no reset needed
  always_ff @(posedge clk) begin
    if (cs_act && sck_rise && bit_cnt < FRAME_BITS)
      rx_sr <= {rx_sr[FRAME_BITS-2:0], sdi_s};
  end

  // addr completes on the 8th rise, last bit still on sdi_s
  assign rd_addr = {rx_sr[dmm_pkg::ADDR_W-2:0], sdi_s};

  // readback. load after addr byte, move on falling sck
  always_ff @(posedge clk) begin
    if (reset_i || cs_rise)
      tx_sr <= '1;                           // sdo idles high
    else if (cs_act && sck_rise && bit_cnt == 6'd7)
      tx_sr <= read_word(rd_addr);           // bit 31 out before data rise 1
    else if (cs_act && sck_fall && bit_cnt > 6'd8 && bit_cnt < FRAME_BITS)
      tx_sr <= {tx_sr[dmm_pkg::REG_W-2:0], 1'b1};
  end

  assign sdo_o = tx_sr[dmm_pkg::REG_W-1];

  //////////////////////////////////////////////////////////////////////
  // register file

  assign wr_addr = rx_sr[FRAME_BITS-2 -: dmm_pkg::ADDR_W];
  assign wr_en   = cs_rise && (bit_cnt == FRAME_BITS) && !overrun
                   && rx_sr[FRAME_BITS-1] && is_rw(wr_addr);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int a = dmm_pkg::REG_MODE; a <= dmm_pkg::REG_APERTURE; a++) begin
        regs[a] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= rx_sr[dmm_pkg::REG_W-1:0];
    end
  end

  assign status = {9'b0, cfg_o.seq_n, 1'b0, sample_idx_last_i,
                   4'b0, hw_flags_i, dmm_pkg::STATUS_MAGIC};

  assign mode_o   = regs[dmm_pkg::REG_MODE][2:0];
  assign direct_o = regs[dmm_pkg::REG_DIRECT][$bits(dmm_pkg::out_bundle_t)-1:0];

  always_comb begin
    cfg_o       = '0;
    cfg_o.trig  = regs[dmm_pkg::REG_TRIG][0];
    cfg_o.seq_n = regs[dmm_pkg::REG_SEQ_N][2:0];
    for (int i = 0; i < dmm_pkg::SEQ_MAX; i++) begin
      cfg_o.seq[i] = regs[dmm_pkg::REG_SEQ0 + i][$bits(dmm_pkg::seq_entry_t)-1:0];
    end
    cfg_o.precharge[TIMER_W-1:0] = regs[dmm_pkg::REG_PRECHARGE][TIMER_W-1:0];
    cfg_o.aperture[TIMER_W-1:0]  = regs[dmm_pkg::REG_APERTURE][TIMER_W-1:0];
  end

  a_bit_cnt_bound: assert property (@(posedge clk) disable iff (reset_i)
    cs_act |-> bit_cnt <= 6'(FRAME_BITS));

endmodule

`default_nettype wire

/* sim/tb_dmm_top.sv */
/*
  spi master bit-banged on clk with 6 clk sck half periods.
  adc_reset_n has no pin, so bundle compares hold it at 0 on both sides.
*/

`timescale 1ns/100ps
`default_nettype none

module tb_dmm_top;

  localparam int TIMER_W  = 24;
  localparam int SCK_HALF = 6;       // clk per sck half period
  localparam int TIMEOUT  = 4000;    // clk per wait
  localparam int SEQ_LEN  = 3;

  logic       clk;
  logic       reset_i;
  logic       spi_sck_i;
  logic       spi_sdi_i;
  logic       spi_cs_n_i;
  logic [3:0] hw_flags_i;
  logic       spi_sdo_o;
  logic [3:0] leds_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;
  logic [3:0] azmux_o;
  logic [3:0] adc_refmux_o;
  logic       adc_cmpr_latch_ctl_o;
  logic       spi_interrupt_ctl_o;
  logic       meas_complete_o;

  logic [31:0] shadow [0:15];        // last value written per register
  logic [31:0] lcg_state = 32'd35424;
  logic        seq_check_en = 1'b0;
  int          pulse_cnt = 0;        // meas_complete pulses since enable

  dmm_top #(
    .TIMER_W (TIMER_W)
  ) dut_i (
    .clk                  (clk),
    .reset_i              (reset_i),
    .spi_sck_i            (spi_sck_i),
    .spi_sdi_i            (spi_sdi_i),
    .spi_cs_n_i           (spi_cs_n_i),
    .spi_sdo_o            (spi_sdo_o),
    .hw_flags_i           (hw_flags_i),
    .leds_o               (leds_o),
    .monitor_o            (monitor_o),
    .pc_sw_o              (pc_sw_o),
    .azmux_o              (azmux_o),
    .adc_refmux_o         (adc_refmux_o),
    .adc_cmpr_latch_ctl_o (adc_cmpr_latch_ctl_o),
    .spi_interrupt_ctl_o  (spi_interrupt_ctl_o),
    .meas_complete_o      (meas_complete_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;          // 100 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // helpers and reference model

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // pins gathered back into the bundle type
  function automatic dmm_pkg::out_bundle_t pins_bundle();
    dmm_pkg::out_bundle_t b;
    b = '0;
    b.leds           = leds_o;
    b.monitor        = monitor_o;
    b.pc_sw          = pc_sw_o;
    b.azmux          = azmux_o;
    b.adc_refmux     = adc_refmux_o;
    b.adc_cmpr_latch = adc_cmpr_latch_ctl_o;
    b.spi_interrupt  = spi_interrupt_ctl_o;
    b.meas_complete  = meas_complete_o;
    return b;
  endfunction

  function automatic logic [31:0] expect_status(input logic [2:0] last_idx);
    logic [31:0] w;
    w        = '0;
    w[7:0]   = 8'hAA;                            // magic
    w[11:8]  = hw_flags_i;
    w[18:16] = last_idx;
    w[22:20] = shadow[dmm_pkg::REG_SEQ_N][2:0];
    return w;
  endfunction

  // pins during the k-th meas_complete pulse
  function automatic dmm_pkg::out_bundle_t expect_sample(input int k);
    dmm_pkg::out_bundle_t b;
    dmm_pkg::seq_entry_t  e;
    int n;
    int idx;
    n = int'(shadow[dmm_pkg::REG_SEQ_N][2:0]);
    if (n == 0)
      n = 1;                           // seq_n 0 runs one entry
    idx = k % n;
    e = shadow[dmm_pkg::REG_SEQ0 + idx][5:0];
    b = '0;
    b.leds          = 4'b0001 << idx;
    b.monitor       = {3'b0, 3'(idx), 2'd3};   // index and COMPLETE state
    b.pc_sw         = e.pc_sw;
    b.azmux         = e.azmux;
    b.spi_interrupt = 1'b1;
    b.meas_complete = 1'b1;
    return b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                              $time, name, got, exp));
  endtask

  task automatic check_bundle(input string name, input dmm_pkg::out_bundle_t got,
                              input dmm_pkg::out_bundle_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                              $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                              $time, name, got, exp));
  endtask

  // pins sampled mid-cycle against the reference
  always @(negedge clk) begin
    if (!seq_check_en) begin
      pulse_cnt = 0;
    end else if (meas_complete_o) begin
      check_bundle($sformatf("pins at pulse %0d", pulse_cnt), pins_bundle(),
                   expect_sample(pulse_cnt));
      pulse_cnt = pulse_cnt + 1;
    end else begin
      check_bit("spi_interrupt_ctl_o", spi_interrupt_ctl_o, 1'b0);  // irq only with a pulse
    end
  end

  //////////////////////////////////////////////////////////////////////
  // spi master

  task automatic spi_frame(input logic wr, input logic [6:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    @(posedge clk);
    spi_cs_n_i <= 1'b0;
    repeat (SCK_HALF) @(posedge clk);
    for (int i = 39; i >= 0; i--) begin
      spi_sdi_i <= frame[i];
      repeat (SCK_HALF - 1) @(posedge clk);
      @(negedge clk);
      if (i < 32) rdata[i] = spi_sdo_o;   // sampled just before the rise
      @(posedge clk);
      spi_sck_i <= 1'b1;
      repeat (SCK_HALF) @(posedge clk);
      spi_sck_i <= 1'b0;
    end
    repeat (SCK_HALF) @(posedge clk);
    spi_cs_n_i <= 1'b1;
    repeat (SCK_HALF) @(posedge clk);     // commit takes 4 clk and the mux 1 more
  endtask

  task automatic reg_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    spi_frame(1'b1, addr, data, unused_rd);
    if (addr >= dmm_pkg::REG_MODE && addr <= dmm_pkg::REG_APERTURE)
      shadow[addr] = data;
  endtask

  task automatic reg_read(input logic [6:0] addr, output logic [31:0] data);
    spi_frame(1'b0, addr, 32'h0, data);
  endtask

  task automatic wait_pulses(input int n);
    int waited;
    waited = 0;
    while (pulse_cnt < n) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT)
        stop_on_error($sformatf("timed out waiting for %0d meas_complete pulses", n));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // scenarios

  initial begin
    logic [31:0] rd;
    logic [6:0]  addr;
    logic [2:0]  last_idx;
    dmm_pkg::out_bundle_t exp_b;
    for (int a = 0; a < 16; a++) begin
      shadow[a] = '0;
    end
    reset_i    <= 1'b1;
    spi_sck_i  <= 1'b0;
    spi_sdi_i  <= 1'b0;
    spi_cs_n_i <= 1'b1;
    hw_flags_i <= 4'b1101;
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;

    // reset state
    @(negedge clk);
    check_bundle("pins after reset", pins_bundle(), '0);
    check_bit("spi_sdo_o", spi_sdo_o, 1'b1);
    reg_read(dmm_pkg::REG_STATUS, rd);
    check_word("status after reset", rd, expect_status(3'd0));

    // status ignores writes and unknown addresses read 0
    reg_write(dmm_pkg::REG_STATUS, next_rand());
    reg_read(dmm_pkg::REG_STATUS, rd);
    check_word("status after write", rd, expect_status(3'd0));
    addr = 7'(32'd11 + next_rand() % 32'd117);
    reg_write(addr, next_rand());
    reg_read(addr, rd);
    check_word($sformatf("unknown reg %0d", addr), rd, 32'h0);

    // round trip over every writable register
    for (int a = dmm_pkg::REG_MODE; a <= dmm_pkg::REG_APERTURE; a++)
      reg_write(7'(a), next_rand());
    for (int a = dmm_pkg::REG_MODE; a <= dmm_pkg::REG_APERTURE; a++) begin
      reg_read(7'(a), rd);
      check_word($sformatf("reg %0d", a), rd, shadow[a]);
    end
    reg_write(dmm_pkg::REG_TRIG, 32'h0);
    reg_write(dmm_pkg::REG_MODE, 32'(dmm_pkg::MODE_DIRECT));

    // direct mode and then an unused mode
    reg_write(dmm_pkg::REG_DIRECT, next_rand());
    exp_b = shadow[dmm_pkg::REG_DIRECT][25:0];
    exp_b.adc_reset_n = 1'b0;        // no pin
    @(negedge clk);
    check_bundle("direct pins", pins_bundle(), exp_b);
    reg_write(dmm_pkg::REG_MODE, 32'd3);
    @(negedge clk);
    check_bundle("unused mode pins", pins_bundle(), '0);

    // sequencer with three random entries and short intervals
    for (int i = 0; i < dmm_pkg::SEQ_MAX; i++)
      reg_write(7'(dmm_pkg::REG_SEQ0 + i), next_rand());
    reg_write(dmm_pkg::REG_SEQ_N, 32'(SEQ_LEN));
    reg_write(dmm_pkg::REG_PRECHARGE, next_rand() & 32'h7);
    reg_write(dmm_pkg::REG_APERTURE, next_rand() & 32'hF);
    reg_write(dmm_pkg::REG_MODE, 32'(dmm_pkg::MODE_SEQ_MOCK));
    seq_check_en = 1'b1;
    reg_write(dmm_pkg::REG_TRIG, 32'h1);
    wait_pulses(7);
    reg_write(dmm_pkg::REG_TRIG, 32'h0);
    last_idx = 3'((pulse_cnt - 1) % SEQ_LEN);   // sequencer stops before the enable drops
    seq_check_en = 1'b0;

    // last sample index readback
    reg_read(dmm_pkg::REG_STATUS, rd);
    check_word("status after sequence", rd, expect_status(last_idx));

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
